//--- common/rvCore_settings.svh
// rvCore build settings covering datapath widths, reset vector and NOP word
`ifndef RVCORE_SETTINGS_SVH
`define RVCORE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Data and address width
`define XLEN 32

// Register index, 32 architectural registers
`define REG_ADDR_W 5

//////////////////////////////////////////////////////////////////////
// Reset and filler values
//////////////////////////////////////////////////////////////////////

`define RESET_PC 32'h0000_0000   // First fetch address

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

//--- common/rvCorePkg.sv
// rvCore shared types for opcodes, ALU and branch codes, control word and stage records
`include "rvCore_settings.svh"

package rvCorePkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011,
    R_OP   = 7'b0110011,
    FENCE  = 7'b0001111   // Treated as NOP
  } opcodeT;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SUB  = 4'b1000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    SRA  = 4'b1101,
    OR   = 4'b0110,
    AND  = 4'b0111
  } aluOpT;

  // Branch condition, straight from funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchT;

  typedef enum logic [2:0] {I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE} immTypeT;

  //////////////////////////////////////////////////////////////////////
  // Control word and stage records
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    aluOpT  aluOp;
    branchT branchOp;
    logic   isBranch;
    logic   isJump;     // JAL or JALR
    logic   selAluPc;   // ALU input 1 is the PC
    logic   selAluImm;  // ALU input 2 is the immediate
    logic   isLui;
    logic   regWrEn;    // Never set for rd == x0
    logic   linkWr;     // Write PC+4 instead of ALU result
    logic   memRd;
    logic   memWr;
  } ctrlT;

  // Q102, execute input
  typedef struct packed {
    ctrlT                   ctrl;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       pcPlus4;
    logic [`XLEN-1:0]       immediate;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1Data;   // As read in decode, before forwarding
    logic [`XLEN-1:0]       rs2Data;
  } decodedT;

  // Q103, memory access
  typedef struct packed {
    logic [`XLEN-1:0]       aluOut;
    logic [`XLEN-1:0]       storeData;
    logic [`XLEN-1:0]       pcPlus4;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   regWrEn;
    logic                   linkWr;
    logic                   memRd;
    logic                   memWr;
  } memStageT;

  // Q104 register write
  typedef struct packed {
    logic                   wrEn;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wbT;

  typedef struct packed {
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] wrData;
    logic             wrEn;
    logic             rdEn;
  } dmemReqT;

endpackage

//--- design/decode/regFile.sv
// Register file with x1 to x31, x0 reading zero and same-cycle write bypass
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module regFile import rvCorePkg::*; (
  input  logic                   Clk,
  input  logic                   rstN,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  output logic [`XLEN-1:0]       rs1Data,
  output logic [`XLEN-1:0]       rs2Data,
  input  wbT                     wb
);

  logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W) - 1];   // No storage for x0

  // x0 first so a bypass can never leak into it
  function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
    if (addr == '0)
      return '0;
    if (wb.wrEn && (wb.rd == addr))
      return wb.data;                 // Write lands this edge
    return regs[addr];
  endfunction

  always_comb begin
    rs1Data = readPort(rs1);
    rs2Data = readPort(rs2);
  end

  always_ff @(posedge Clk) begin
    if (wb.wrEn && (wb.rd != '0))
      regs[wb.rd] <= wb.data;
  end

  x0ZeroA: assert property (@(posedge Clk) disable iff (!rstN)
    (rs1 == '0) |-> (rs1Data == '0));

endmodule

//--- design/decode/decodeUnit.sv
// Decode stage with control decoder, immediate generator, register read and Q102 register
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module decodeUnit import rvCorePkg::*; (
  input  logic             Clk,
  input  logic             rstN,
  input  logic [`XLEN-1:0] instrQ101,
  input  logic [`XLEN-1:0] pcQ101,
  input  wbT               wb,          // Register write from Q104
  output decodedT          q102
);

  opcodeT                 opcode;
  logic [2:0]             funct3;
  logic                   altOp;      // funct7[5] where it picks SUB or SRA
  logic                   writesRd;
  immTypeT                immType;
  ctrlT                   ctrl;
  logic [`XLEN-1:0]       imm;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       rs1Data;
  logic [`XLEN-1:0]       rs2Data;

  assign opcode = opcodeT'(instrQ101[6:0]);
  assign funct3 = instrQ101[14:12];
  assign rd     = instrQ101[11:7];
  assign rs1    = instrQ101[19:15];
  assign rs2    = instrQ101[24:20];

  // For ADDI bit 30 is immediate, not an opcode modifier
  assign altOp    = instrQ101[30] &&
                    (((opcode == R_OP) && (funct3 == 3'b000)) || (funct3 == 3'b101));
  assign writesRd = opcode inside {LUI, AUIPC, JAL, JALR, LOAD, I_OP, R_OP};

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl           = '0;                            // Unknown opcode acts as NOP
    ctrl.aluOp     = ADD;                           // Address and target adds
    ctrl.branchOp  = branchT'(funct3);
    ctrl.isBranch  = (opcode == BRANCH);
    ctrl.isJump    = (opcode == JAL) || (opcode == JALR);
    ctrl.selAluPc  = (opcode == JAL) || (opcode == BRANCH) || (opcode == AUIPC);
    ctrl.selAluImm = (opcode != R_OP);
    ctrl.isLui     = (opcode == LUI);
    ctrl.regWrEn   = writesRd && (rd != '0);        // x0 writes dropped here
    ctrl.linkWr    = ctrl.isJump;
    ctrl.memRd     = (opcode == LOAD);              // Word access only
    ctrl.memWr     = (opcode == STORE);
    if ((opcode == R_OP) || (opcode == I_OP))
      ctrl.aluOp = aluOpT'({altOp, funct3});
  end

  // Immediate generator
  always_comb begin
    case (opcode)
      LUI, AUIPC: immType = U_TYPE;
      JAL:        immType = J_TYPE;
      BRANCH:     immType = B_TYPE;
      STORE:      immType = S_TYPE;
      default:    immType = I_TYPE;  // JALR, LOAD, I_OP
    endcase
    case (immType)
      U_TYPE:  imm = {instrQ101[31:12], 12'b0};
      S_TYPE:  imm = {{20{instrQ101[31]}}, instrQ101[31:25], instrQ101[11:7]};
      B_TYPE:  imm = {{20{instrQ101[31]}}, instrQ101[7], instrQ101[30:25],
                      instrQ101[11:8], 1'b0};
      J_TYPE:  imm = {{12{instrQ101[31]}}, instrQ101[19:12], instrQ101[20],
                      instrQ101[30:21], 1'b0};
      default: imm = {{20{instrQ101[31]}}, instrQ101[31:20]};
    endcase
  end

  regFile regFile0 (
    .Clk     (Clk),
    .rstN    (rstN),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .wb      (wb)
  );

  //////////////////////////////////////////////////////////////////////
  // Q102 stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      q102.ctrl <= '0;                     // Bubble out of reset
    end else begin
      q102.ctrl      <= ctrl;
      q102.pc        <= pcQ101;
      q102.pcPlus4   <= pcQ101 + `XLEN'(4);  // Link value
      q102.immediate <= imm;
      q102.rs1       <= rs1;
      q102.rs2       <= rs2;
      q102.rd        <= rd;
      q102.rs1Data   <= rs1Data;
      q102.rs2Data   <= rs2Data;
    end
  end

endmodule

//--- design/fetchUnit.sv
// Fetch stage with PC register, next-PC select, load-use stall and Q101 squash
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module fetchUnit import rvCorePkg::*; (
  input  logic             Clk,
  input  logic             rstN,
  input  logic             redirect,    // From execute, same cycle
  input  logic [`XLEN-1:0] target,
  input  decodedT          q102,        // Instruction now in execute
  output logic [`XLEN-1:0] pc,          // To instruction memory
  input  logic [`XLEN-1:0] instr,       // Answers last cycle's pc
  output logic [`XLEN-1:0] instrQ101,
  output logic [`XLEN-1:0] pcQ101
);

  logic [`XLEN-1:0]       rawInstr;    // Memory word or replayed copy
  logic [`XLEN-1:0]       heldInstr;   // Word parked during a stall
  logic                   replay;      // Stalled last cycle
  logic                   killQ101;    // Second slot behind a redirect
  logic                   stall;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;

  assign rawInstr = replay ? heldInstr : instr;
  assign rs1      = rawInstr[19:15];
  assign rs2      = rawInstr[24:20];

  // Load result not ready until Q104, so the consumer waits one slot
  assign stall = q102.ctrl.memRd && q102.ctrl.regWrEn &&
                 ((q102.rd == rs1) || (q102.rd == rs2));

  // Squash first slot on redirect, second slot a cycle later
  assign instrQ101 = (redirect || killQ101 || stall) ? `NOP_INSTR : rawInstr;

  //////////////////////////////////////////////////////////////////////
  // PC and Q101 registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      pc       <= `RESET_PC;
      replay   <= 1'b0;
      killQ101 <= 1'b1;        // Word fetched while in reset is dropped
    end else begin
      replay   <= stall;
      killQ101 <= redirect;
      if (redirect)
        pc <= target;          // Branch target wins
      else if (!stall)
        pc <= pc + `XLEN'(4);  // Held during the bubble
    end
  end

  always_ff @(posedge Clk) begin
    if (!stall)
      pcQ101 <= pc;
    if (stall)
      heldInstr <= rawInstr;   // Replayed next cycle
  end

  // The replayed word sees a bubble in Q102, so it can never stall again
  stallOnceA: assert property (@(posedge Clk) disable iff (!rstN)
    stall |=> !stall);

endmodule

//--- design/executeUnit.sv
// Execute stage with operand forwarding, ALU, branch compare, redirect and Q103 register
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module executeUnit import rvCorePkg::*; (
  input  logic             Clk,
  input  logic             rstN,
  input  decodedT          q102,
  input  wbT               wb,          // Q104 forward source
  output memStageT         q103,
  output logic             redirect,    // To fetch
  output logic [`XLEN-1:0] target
);

  logic [`XLEN-1:0]          q103Fwd;   // Newest value sitting in Q103
  logic [`XLEN-1:0]          src1;
  logic [`XLEN-1:0]          src2;
  logic [`XLEN-1:0]          aluIn1;
  logic [`XLEN-1:0]          aluIn2;
  logic [`XLEN-1:0]          aluOut;
  logic [$clog2(`XLEN)-1:0]  shamt;
  logic                      branchMet;

  // Jumps in Q103 hand on their link value, not the target
  assign q103Fwd = q103.linkWr ? q103.pcPlus4 : q103.aluOut;

  // Q103 over Q104 over decode read, regWrEn already clear for x0
  function automatic logic [`XLEN-1:0] pickSrc(input logic [`REG_ADDR_W-1:0] rs,
                                               input logic [`XLEN-1:0]       rfData);
    if (q103.regWrEn && (q103.rd == rs))
      return q103Fwd;
    if (wb.wrEn && (wb.rd == rs))
      return wb.data;
    return rfData;
  endfunction

  always_comb begin
    src1 = pickSrc(q102.rs1, q102.rs1Data);
    src2 = pickSrc(q102.rs2, q102.rs2Data);
  end

  assign aluIn1 = q102.ctrl.selAluPc  ? q102.pc        : src1;
  assign aluIn2 = q102.ctrl.selAluImm ? q102.immediate : src2;

  //////////////////////////////////////////////////////////////////////
  // ALU and branch compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    shamt = aluIn2[$clog2(`XLEN)-1:0];
    case (q102.ctrl.aluOp)
      SUB:     aluOut = aluIn1 - aluIn2;
      SLL:     aluOut = aluIn1 << shamt;
      SLT:     aluOut = {{(`XLEN-1){1'b0}}, $signed(aluIn1) < $signed(aluIn2)};
      SLTU:    aluOut = {{(`XLEN-1){1'b0}}, aluIn1 < aluIn2};
      XOR:     aluOut = aluIn1 ^ aluIn2;
      SRL:     aluOut = aluIn1 >> shamt;
      SRA:     aluOut = $signed(aluIn1) >>> shamt;
      OR:      aluOut = aluIn1 | aluIn2;
      AND:     aluOut = aluIn1 & aluIn2;
      default: aluOut = aluIn1 + aluIn2;   // ADD, addresses, targets
    endcase
    if (q102.ctrl.isLui)
      aluOut = aluIn2;                     // Immediate straight through
  end

  always_comb begin
    case (q102.ctrl.branchOp)
      BEQ:     branchMet = (src1 == src2);
      BNE:     branchMet = (src1 != src2);
      BLT:     branchMet = ($signed(src1) < $signed(src2));
      BGE:     branchMet = ($signed(src1) >= $signed(src2));
      BLTU:    branchMet = (src1 < src2);
      BGEU:    branchMet = (src1 >= src2);
      default: branchMet = 1'b0;
    endcase
  end

  assign redirect = (q102.ctrl.isBranch && branchMet) || q102.ctrl.isJump;
  assign target   = {aluOut[`XLEN-1:1], 1'b0};   // JALR low bit, others already even

  //////////////////////////////////////////////////////////////////////
  // Q103 stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      q103.regWrEn <= 1'b0;
      q103.linkWr  <= 1'b0;
      q103.memRd   <= 1'b0;
      q103.memWr   <= 1'b0;
    end else begin
      q103.aluOut    <= aluOut;          // Address for LW and SW
      q103.storeData <= src2;            // Forwarded store data
      q103.pcPlus4   <= q102.pcPlus4;
      q103.rd        <= q102.rd;
      q103.regWrEn   <= q102.ctrl.regWrEn;
      q103.linkWr    <= q102.ctrl.linkWr;
      q103.memRd     <= q102.ctrl.memRd;
      q103.memWr     <= q102.ctrl.memWr;
    end
  end

endmodule

//--- design/memWriteback.sv
// Memory and write-back stages with data memory request, Q104 register and result select
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module memWriteback import rvCorePkg::*; (
  input  logic             Clk,
  input  logic             rstN,
  input  memStageT         q103,
  output dmemReqT          dmemReq,
  input  logic [`XLEN-1:0] dmemRdData,   // Answers last cycle's rdEn
  output wbT               wb
);

  logic                   regWrEnQ104;
  logic                   loadQ104;      // Take memory data
  logic [`REG_ADDR_W-1:0] rdQ104;
  logic [`XLEN-1:0]       resultQ104;    // Link value or ALU result

  // Q103 request, word access only
  assign dmemReq.address = q103.aluOut;
  assign dmemReq.wrData  = q103.storeData;
  assign dmemReq.wrEn    = q103.memWr;
  assign dmemReq.rdEn    = q103.memRd;

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      regWrEnQ104 <= 1'b0;
      loadQ104    <= 1'b0;
    end else begin
      regWrEnQ104 <= q103.regWrEn;
      loadQ104    <= q103.memRd;
    end
  end

  always_ff @(posedge Clk) begin
    rdQ104     <= q103.rd;
    resultQ104 <= q103.linkWr ? q103.pcPlus4 : q103.aluOut;
  end

  assign wb = '{wrEn: regWrEnQ104,
                rd:   rdQ104,
                data: loadQ104 ? dmemRdData : resultQ104};

  // Load and store come from distinct opcodes in decode
  memExclusiveA: assert property (@(posedge Clk) disable iff (!rstN)
    !(dmemReq.wrEn && dmemReq.rdEn));

endmodule

//--- design/rvCore.sv
// rvCore top, five-stage RV32I pipeline from fetch through write-back
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvCore import rvCorePkg::*; (
  input  logic             Clk,
  input  logic             rstN,
  // Instruction memory
  output logic [`XLEN-1:0] pc,          // Q100 fetch address
  input  logic [`XLEN-1:0] instr,       // One cycle after pc
  // Data memory
  output dmemReqT          dmemReq,     // Q103 request
  input  logic [`XLEN-1:0] dmemRdData   // Q104 response
);

  logic [`XLEN-1:0] instrQ101;
  logic [`XLEN-1:0] pcQ101;
  decodedT          q102;
  memStageT         q103;
  wbT               wb;         // Register write, also Q104 forward
  logic             redirect;   // Taken branch or jump
  logic [`XLEN-1:0] target;

  //////////////////////////////////////////////////////////////////////
  // Front end
  //////////////////////////////////////////////////////////////////////

  fetchUnit fetch0 (
    .Clk       (Clk),
    .rstN      (rstN),
    .redirect  (redirect),
    .target    (target),
    .q102      (q102),       // Load-use view
    .pc        (pc),
    .instr     (instr),
    .instrQ101 (instrQ101),
    .pcQ101    (pcQ101)
  );

  decodeUnit decode0 (
    .Clk       (Clk),
    .rstN      (rstN),
    .instrQ101 (instrQ101),
    .pcQ101    (pcQ101),
    .wb        (wb),
    .q102      (q102)
  );

  //////////////////////////////////////////////////////////////////////
  // Back end
  //////////////////////////////////////////////////////////////////////

  executeUnit execute0 (
    .Clk       (Clk),
    .rstN      (rstN),
    .q102      (q102),
    .wb        (wb),
    .q103      (q103),
    .redirect  (redirect),
    .target    (target)
  );

  memWriteback memWb0 (
    .Clk        (Clk),
    .rstN       (rstN),
    .q103       (q103),
    .dmemReq    (dmemReq),
    .dmemRdData (dmemRdData),
    .wb         (wb)
  );

endmodule

//--- bench/rvCoreChecker.sv
// rvCore store checker comparing data memory writes with the model and watching reset
`timescale 1ns/1ps

module rvCoreChecker import rvCorePkg::*; #(
  parameter int maxStores = 128
) (
  input  logic        Clk,
  input  logic        rstN,
  input  dmemReqT     dmemReq,
  input  logic [63:0] expStores [maxStores],   // {address, data}, program order
  input  int          expCount,
  output int          errors,
  output int          seen                     // Expected stores consumed so far
);

  int          errCount   = 0;
  int          seenCount  = 0;
  int          sinceReset = 0;   // Negedges since rstN release, saturates at 3
  logic [31:0] expAddr;
  logic [31:0] expData;

  assign errors = errCount;
  assign seen   = seenCount;

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      errCount++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampling at the falling edge, request is stable there
  //////////////////////////////////////////////////////////////////////

  always @(negedge Clk) begin
    if (!rstN)
      sinceReset = 0;
    else if (sinceReset < 3)
      sinceReset++;

    // Quiet window is reset plus two cycles
    if ((sinceReset <= 2) && (dmemReq.wrEn || dmemReq.rdEn)) begin
      $display("Data memory strobe active during or right after reset (wrEn %b, rdEn %b) at %0t",
               dmemReq.wrEn, dmemReq.rdEn, $time);
      errCount++;
    end

    if (rstN && dmemReq.wrEn) begin
      if (seenCount >= expCount) begin
        // Squashed slot or runaway fetch
        $display("Unexpected data memory write to %h with data %h, all %0d stores already seen",
                 dmemReq.address, dmemReq.wrData, expCount);
        errCount++;
      end else begin
        expAddr = expStores[seenCount][63:32];
        expData = expStores[seenCount][31:0];
        checkWord($sformatf("store %0d address", seenCount), expAddr, dmemReq.address);
        checkWord($sformatf("store %0d data", seenCount), expData, dmemReq.wrData);
        seenCount++;
      end
    end
  end

endmodule

//--- bench/rvCoreTb.sv
// rvCore testbench with memory models, random program, instruction-set model and watchdog
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvCoreTb import rvCorePkg::*; ();

  localparam int clkPeriod      = 8;
  localparam int prologueLen    = 31;                      // ADDI x1..x31
  localparam int bodyLen        = 64;
  localparam int bodyEnd        = prologueLen + bodyLen;   // Epilogue start index
  localparam int progLen        = bodyEnd + 33;            // 32 dumps plus spin
  localparam int imemWords      = 256;
  localparam int dmemWords      = 256;
  localparam int maxStores      = 128;
  localparam int watchdogCycles = progLen * 10 + 100;
  localparam int drainCycles    = 20;

  logic             Clk;
  logic             rstN;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] instr;
  dmemReqT          dmemReq;
  logic [`XLEN-1:0] dmemRdData;

  logic [31:0] imem [imemWords];
  logic [31:0] dmem [dmemWords];
  logic [31:0] fetchAddr;                // pc seen at the falling edge
  dmemReqT     reqSeen;
  logic [63:0] expStores [maxStores];
  int          expCount;
  int          benchErrors;
  int          errors;
  int          seen;
  logic [31:0] lcgState;
  logic [4:0]  recent [3];               // Last three destinations
  logic        isTarget [imemWords];     // Landing slots of branches and jumps

  rvCore dut0 (
    .Clk        (Clk),
    .rstN       (rstN),
    .pc         (pc),
    .instr      (instr),
    .dmemReq    (dmemReq),
    .dmemRdData (dmemRdData)
  );

  rvCoreChecker #(.maxStores(maxStores)) checker0 (
    .Clk       (Clk),
    .rstN      (rstN),
    .dmemReq   (dmemReq),
    .expStores (expStores),
    .expCount  (expCount),
    .errors    (errors),
    .seen      (seen)
  );

  always #(clkPeriod / 2) Clk = ~Clk;

  //////////////////////////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////////////////////////

  always @(negedge Clk) begin
    fetchAddr = pc;
    reqSeen   = dmemReq;
  end

  // One cycle read latency, write lands at the edge
  always @(posedge Clk) begin
    #1;
    instr = imem[fetchAddr[9:2]];
    if (reqSeen.wrEn)
      dmem[reqSeen.address[9:2]] = reqSeen.wrData;
    if (reqSeen.rdEn)
      dmemRdData = dmem[reqSeen.address[9:2]];
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and encoders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic int randBelow(input int n);
    logic [31:0] r;
    r = nextRand();
    return int'(r[30:16]) % n;   // High bits, low ones cycle fast
  endfunction

  // Mostly recent destinations, so forwarding and load-use show up
  function automatic logic [4:0] pickSrc();
    if (randBelow(4) != 0)
      return recent[randBelow(3)];
    return 5'(randBelow(32));
  endfunction

  function automatic logic [4:0] pickDest();
    logic [4:0] d;
    d         = 5'(randBelow(32));   // x0 now and then
    recent[2] = recent[1];
    recent[1] = recent[0];
    recent[0] = d;
    return d;
  endfunction

  // Forward landing slot, never past the epilogue start
  function automatic int pickTarget(input int from);
    int t;
    t = from + 2 + randBelow(3);
    if (t > bodyEnd)
      t = bodyEnd;
    isTarget[t] = 1'b1;
    return t;
  endfunction

  function automatic logic [31:0] fillWord(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};   // SW
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Program generator
  //////////////////////////////////////////////////////////////////////

  task automatic makeProgram();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] tmp;
    int          kind;
    int          idx;
    int          t;
    for (int w = 0; w < imemWords; w++) begin
      imem[w]     = `NOP_INSTR;
      isTarget[w] = 1'b0;
    end
    recent = '{5'd1, 5'd2, 5'd3};
    for (int r = 1; r < 32; r++) begin
      tmp          = nextRand();
      imem[r - 1]  = encI(tmp[11:0], 5'd0, 3'd0, 5'(r), 7'h13);   // Known start values
    end
    idx = prologueLen;
    while (idx < bodyEnd) begin
      kind = randBelow(16);
      if ((kind == 15) && ((idx > bodyEnd - 2) || isTarget[idx + 1]))
        kind = 5;   // No room for the LUI/JALR pair
      if (kind < 5) begin                              // R-type
        f3  = 3'(randBelow(8));
        alt = ((f3 == 3'd0) || (f3 == 3'd5)) && (randBelow(2) == 1);
        rs1 = pickSrc();
        rs2 = pickSrc();
        rd  = pickDest();
        imem[idx] = encR(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33);
      end else if (kind < 9) begin                     // Immediate ALU
        f3  = 3'(randBelow(8));
        rs1 = pickSrc();
        rd  = pickDest();
        tmp = nextRand();
        if (f3 == 3'd1)
          tmp = {27'b0, tmp[4:0]};                     // SLLI
        else if (f3 == 3'd5)
          tmp = {21'b0, tmp[10], 5'b0, tmp[4:0]};      // SRLI or SRAI
        imem[idx] = encI(tmp[11:0], rs1, f3, rd, 7'h13);
      end else if (kind < 11) begin                    // LUI, AUIPC
        tmp = nextRand();
        rd  = pickDest();
        imem[idx] = {tmp[31:12], rd, (kind == 9) ? 7'h37 : 7'h17};
      end else if (kind == 11) begin
        rs2 = pickSrc();
        imem[idx] = encS(12'h100 + 12'(4 * randBelow(16)), rs2, 5'd0);
      end else if (kind == 12) begin                   // LW from the window
        rd = pickDest();
        imem[idx] = encI(12'h100 + 12'(4 * randBelow(16)), 5'd0, 3'b010, rd, 7'h03);
      end else if (kind == 13) begin
        f3 = 3'(randBelow(6));
        if (f3 >= 3'd2)
          f3 = f3 + 3'd2;                              // 0, 1, 4..7
        rs1 = pickSrc();
        rs2 = pickSrc();
        t   = pickTarget(idx);
        imem[idx] = encB(13'((t - idx) * 4), rs2, rs1, f3);
      end else if (kind == 14) begin
        rd = pickDest();
        t  = pickTarget(idx);
        imem[idx] = encJ(21'((t - idx) * 4), rd);
      end else begin                                   // LUI base then JALR
        rs1 = pickDest();
        rd  = pickDest();
        t   = pickTarget(idx + 1);
        imem[idx]     = {20'd0, rs1, 7'h37};
        imem[idx + 1] = encI(12'(t * 4 + randBelow(2)), rs1, 3'b000, rd, 7'h67);   // Odd sometimes
        idx++;
      end
      idx++;
    end
    for (int r = 0; r < 32; r++)
      imem[bodyEnd + r] = encS(12'h200 + 12'(4 * r), 5'(r), 5'd0);   // Register dump
    imem[bodyEnd + 32] = encJ(21'd0, 5'd0);                          // Spin
  endtask

  //////////////////////////////////////////////////////////////////////
  // Instruction-set model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic runModel();
    logic [31:0] rf [32];
    logic [31:0] mem [dmemWords];
    logic [31:0] pcM;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic [31:0] addr;
    logic [31:0] immI;
    logic [31:0] immS;
    logic        wr;
    int          steps;
    for (int r = 0; r < 32; r++)
      rf[r] = '0;
    for (int w = 0; w < dmemWords; w++)
      mem[w] = fillWord(32'(w * 4));
    pcM      = `RESET_PC;
    steps    = 0;
    expCount = 0;
    while ((pcM != 32'((bodyEnd + 32) * 4)) && (steps < 4000)) begin
      ins    = imem[pcM[9:2]];
      a      = rf[ins[19:15]];
      b      = rf[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      nextPc = pcM + 32'd4;
      wr     = 1'b1;
      res    = '0;
      case (ins[6:0])
        7'h37: res = {ins[31:12], 12'b0};
        7'h17: res = pcM + {ins[31:12], 12'b0};
        7'h6F: begin
          res    = pcM + 32'd4;
          nextPc = pcM + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h67: begin
          res    = pcM + 32'd4;
          nextPc = (a + immI) & ~32'd1;
        end
        7'h63: begin
          wr = 1'b0;
          if (branchTaken(ins[14:12], a, b))
            nextPc = pcM + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'h03: begin
          addr = a + immI;
          res  = mem[addr[9:2]];
        end
        7'h23: begin
          wr   = 1'b0;
          addr = a + immS;
          mem[addr[9:2]] = b;
          if (expCount < maxStores)
            expStores[expCount] = {addr, b};
          else
            benchErrors++;
          expCount++;
        end
        7'h13: res = aluModel(ins[14:12], (ins[14:12] == 3'd5) && ins[30], a, immI);
        7'h33: res = aluModel(ins[14:12], ins[30], a, b);
        default: wr = 1'b0;
      endcase
      if (wr && (ins[11:7] != 5'd0))
        rf[ins[11:7]] = res;
      pcM = nextPc;
      steps++;
    end
    if (steps >= 4000) begin
      $display("Reference model never reached the spin loop of the program");
      benchErrors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    Clk         = 1'b0;
    rstN        = 1'b0;
    instr       = `NOP_INSTR;
    dmemRdData  = '0;
    fetchAddr   = '0;
    reqSeen     = '0;
    benchErrors = 0;
    lcgState    = 32'd63;   // Seed
    makeProgram();
    runModel();
    for (int w = 0; w < dmemWords; w++)
      dmem[w] = fillWord(32'(w * 4));
    repeat (3) @(posedge Clk);
    #1 rstN = 1'b1;
    wait (seen >= expCount);
    repeat (drainCycles) @(posedge Clk);   // Stray writes behind the last dump
    $display("Summary: %0d of %0d stores checked, %0d errors",
             seen, expCount, errors + benchErrors);
    if ((errors + benchErrors) == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Timeout after %0d cycles, only %0d of %0d expected stores seen",
             watchdogCycles, seen, expCount);
    $display("Summary: %0d of %0d stores checked, %0d errors",
             seen, expCount, errors + benchErrors + 1);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- rvCore.f
+incdir+common
common/rvCorePkg.sv
design/decode/regFile.sv
design/decode/decodeUnit.sv
design/fetchUnit.sv
design/executeUnit.sv
design/memWriteback.sv
design/rvCore.sv
bench/rvCoreChecker.sv
bench/rvCoreTb.sv

//--- Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = rvCoreTb
FLIST  = rvCore.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
